// ==== logic/cp0_pkg.sv ====
`default_nettype none

package cp0_pkg;

    import mips_pkg::*;

    // Status (CP0 reg 12), only the fields this core implements
    typedef struct packed {
        logic [15:0] reserved_31_16;
        logic [7:0]  IM;
        logic [4:0]  reserved_7_3;
        logic        ERL;
        logic        EXL;
        logic        IE;
    } cp0_status_t;

    // Cause (CP0 reg 13)
    typedef struct packed {
        logic        BD;
        logic        TI;
        logic [13:0] reserved_29_16;
        // IP[7:2] hardware lines, IP[1:0] software
        logic [7:0]  IP;
        logic        reserved_7;
        exc_code_t   ExcCode;
        logic [1:0]  reserved_1_0;
    } cp0_cause_t;

    // register numbers for mtc0 / mfc0, select 0 only
    typedef enum logic [4:0] {
        cp0_badvaddr = 5'd8,
        cp0_count    = 5'd9,
        cp0_compare  = 5'd11,
        cp0_status   = 5'd12,
        cp0_cause    = 5'd13,
        cp0_epc      = 5'd14
    } cp0_reg_t;

    // mtc0 write port
    typedef struct packed {
        logic     valid;
        cp0_reg_t addr;
        word_t    data;
    } cp0_write_t;

    // boot state, ERL set so interrupts stay off until software clears it
    localparam cp0_status_t status_reset = '{
        reserved_31_16: '0, IM: '0, reserved_7_3: '0, ERL: 1'b1, EXL: 1'b0, IE: 1'b0
    };

endpackage

`default_nettype wire

// ==== logic/cp0_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_regs
    import mips_pkg::*;
    import cp0_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [n_hw_int-1:0] ext_int_sync,
    input  exception_t          exception,
    input  logic                eret,
    input  cp0_write_t          cp0_wr,
    input  cp0_reg_t            cp0_raddr,
    output word_t               cp0_rdata,
    output cp0_status_t         cp0_status,
    output logic [7:0]          interrupt_info,
    output word_t               epc
);

    cp0_status_t status_q;
    cp0_status_t status_wr;
    cp0_cause_t  cause_q;
    cp0_cause_t  cause_wr;
    cp0_cause_t  cause_view;
    word_t       epc_q;
    word_t       badvaddr_q;
    word_t       count_q;
    word_t       compare_q;
    logic        count_tick;
    logic        ti_q;
    logic        exc_commit;
    logic        eret_commit;
    logic        wr_commit;
    logic        addr_exc;

    // a committing exception cancels eret and mtc0 of the same instruction
    assign exc_commit  = exception.valid;
    assign eret_commit = eret & ~exception.valid;
    assign wr_commit   = cp0_wr.valid & ~exception.valid;
    assign addr_exc    = (exception.code == code_adel) || (exception.code == code_ades);

    assign status_wr = cp0_wr.data;
    assign cause_wr  = cp0_wr.data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_q <= status_reset;
        end else if (exc_commit) begin
            status_q.EXL <= 1'b1;
        end else if (eret_commit) begin
            // error level is left first
            if (status_q.ERL) begin
                status_q.ERL <= 1'b0;
            end else begin
                status_q.EXL <= 1'b0;
            end
        end else if (wr_commit && cp0_wr.addr == cp0_pkg::cp0_status) begin
            status_q.IM  <= status_wr.IM;
            status_q.ERL <= status_wr.ERL;
            status_q.EXL <= status_wr.EXL;
            status_q.IE  <= status_wr.IE;
        end
    end

    // stored Cause holds BD, ExcCode and the software IP bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cause_q <= '0;
        end else if (exc_commit) begin
            if (!status_q.EXL) begin
                cause_q.BD <= exception.in_delay_slot;
            end
            cause_q.ExcCode <= exception.code;
        end else if (wr_commit && cp0_wr.addr == cp0_cause) begin
            cause_q.IP[1:0] <= cause_wr.IP[1:0];
        end
    end

    // nested exception keeps the first return address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            epc_q <= '0;
        end else if (exc_commit) begin
            if (!status_q.EXL) begin
                epc_q <= exception.in_delay_slot ? exception.pc - 32'd4 : exception.pc;
            end
        end else if (wr_commit && cp0_wr.addr == cp0_epc) begin
            epc_q <= cp0_wr.data;
        end
    end

    // address errors only
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            badvaddr_q <= '0;
        end else if (exc_commit && addr_exc) begin
            badvaddr_q <= exception.badvaddr;
        end
    end

    // Count runs at half the core clock
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_tick <= 1'b0;
            count_q    <= '0;
            compare_q  <= '0;
            ti_q       <= 1'b0;
        end else begin
            count_tick <= ~count_tick;
            if (wr_commit && cp0_wr.addr == cp0_count) begin
                count_q <= cp0_wr.data;
            end else if (count_tick) begin
                count_q <= count_q + 32'd1;
            end
            if (wr_commit && cp0_wr.addr == cp0_compare) begin
                compare_q <= cp0_wr.data;
            end
            // writing Compare acknowledges the timer
            if (wr_commit && cp0_wr.addr == cp0_compare) begin
                ti_q <= 1'b0;
            end else if (count_q == compare_q) begin
                ti_q <= 1'b1;
            end
        end
    end

    // live view with hardware interrupt lines merged in
    always_comb begin
        cause_view         = cause_q;
        cause_view.TI      = ti_q;
        cause_view.IP[7]   = ext_int_sync[5] | ti_q;
        cause_view.IP[6:2] = ext_int_sync[4:0];
    end

    // mfc0
    always_comb begin
        case (cp0_raddr)
            cp0_badvaddr:          cp0_rdata = badvaddr_q;
            cp0_count:             cp0_rdata = count_q;
            cp0_compare:           cp0_rdata = compare_q;
            cp0_pkg::cp0_status:   cp0_rdata = status_q;
            cp0_cause:             cp0_rdata = cause_view;
            cp0_epc:               cp0_rdata = epc_q;
            default:               cp0_rdata = '0;
        endcase
    end

    assign cp0_status     = status_q;
    assign interrupt_info = cause_view.IP & status_q.IM;
    assign epc            = epc_q;

endmodule

`default_nettype wire

// ==== logic/exception.sv ====
`timescale 1ns/1ps
`default_nettype none

module exception
    import mips_pkg::*;
    import cp0_pkg::*;
(
    input  exception_pipeline_t pipe,
    input  logic [7:0]          interrupt_info,
    input  cp0_status_t         cp0_status,
    input  logic                rst_n,
    output logic                exception_valid,
    output word_t               pcexception,
    output exception_t          exception
);

    logic      interrupt_valid;
    logic      instr_exc;
    exc_code_t instr_code;

    // pending and unmasked request, taken only in normal mode with IE set
    assign interrupt_valid = (interrupt_info != 8'h00)
                           & cp0_status.IE
                           & ~cp0_status.EXL
                           & ~cp0_status.ERL;

    // instruction exceptions in commit order, no flag counts on a bubble
    always_comb begin
        instr_exc  = pipe.instr_valid;
        instr_code = code_int;
        if (!pipe.instr_valid) begin
            instr_exc = 1'b0;
        end else if (pipe.exception_instr) begin
            instr_code = code_adel;
        end else if (pipe.exception_ri) begin
            instr_code = code_ri;
        end else if (pipe.exception_of) begin
            instr_code = code_ov;
        end else if (pipe.exception_sys) begin
            instr_code = code_sys;
        end else if (pipe.exception_bp) begin
            instr_code = code_bp;
        end else if (pipe.exception_load) begin
            instr_code = code_adel;
        end else if (pipe.exception_save) begin
            instr_code = code_ades;
        end else begin
            instr_exc = 1'b0;
        end
    end

    assign exception_valid = (interrupt_valid | instr_exc) & rst_n;

    // the interrupt is taken on top of whatever the instruction raised
    always_comb begin
        exception.valid         = exception_valid;
        exception.code          = interrupt_valid ? code_int : instr_code;
        exception.pc            = pipe.pc;
        exception.in_delay_slot = pipe.in_delay_slot;
        exception.badvaddr      = pipe.vaddr;
        exception.location      = exc_entry;
    end

    // single vector, no BEV or IV variants
    assign pcexception = exc_entry;

endmodule

`default_nettype wire

// ==== logic/exception_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exception_top
    import mips_pkg::*;
    import cp0_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [n_hw_int-1:0] ext_int,
    input  exception_pipeline_t pipe,
    input  cp0_write_t          cp0_wr,
    input  cp0_reg_t            cp0_raddr,
    output exception_t          exception,
    output logic                exception_valid,
    output word_t               pcexception,
    output word_t               epc,
    output word_t               cp0_rdata
);

    logic [n_hw_int-1:0] ext_int_sync;
    cp0_status_t         cp0_status;
    logic [7:0]          interrupt_info;

    // external lines into the core clock domain
    int_sync u_int_sync (
        .clk          (clk),
        .rst_n        (rst_n),
        .ext_int      (ext_int),
        .ext_int_sync (ext_int_sync)
    );

    // coprocessor 0, commits the record from the ranking logic
    cp0_regs u_cp0_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .ext_int_sync   (ext_int_sync),
        .exception      (exception),
        .eret           (pipe.eret),
        .cp0_wr         (cp0_wr),
        .cp0_raddr      (cp0_raddr),
        .cp0_rdata      (cp0_rdata),
        .cp0_status     (cp0_status),
        .interrupt_info (interrupt_info),
        .epc            (epc)
    );

    // combinational ranking at commit
    exception u_exception (
        .pipe            (pipe),
        .interrupt_info  (interrupt_info),
        .cp0_status      (cp0_status),
        .rst_n           (rst_n),
        .exception_valid (exception_valid),
        .pcexception     (pcexception),
        .exception       (exception)
    );

endmodule

`default_nettype wire

// ==== logic/int_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_sync
    import mips_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [n_hw_int-1:0] ext_int,
    output logic [n_hw_int-1:0] ext_int_sync
);

    // first stage may go metastable, never read outside this block
    logic [n_hw_int-1:0] sync_meta;
    logic [n_hw_int-1:0] sync_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_meta <= '0;
            sync_q    <= '0;
        end else begin
            sync_meta <= ext_int;
            sync_q    <= sync_meta;
        end
    end

    assign ext_int_sync = sync_q;

endmodule

`default_nettype wire

// ==== logic/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    // number of hardware interrupt lines into Cause.IP[7:2]
    localparam int unsigned n_hw_int = 6;

    // machine word for pc, addresses and data
    typedef logic [31:0] word_t;

    // general exception vector, BEV=0 variant not modelled
    localparam word_t exc_entry = 32'hbfc0_0380;

    // ExcCode values as they appear in Cause[6:2]
    typedef enum logic [4:0] {
        code_int  = 5'd0,
        code_adel = 5'd4,
        code_ades = 5'd5,
        code_sys  = 5'd8,
        code_bp   = 5'd9,
        code_ri   = 5'd10,
        code_ov   = 5'd12
    } exc_code_t;

    // flags from the committing instruction
    typedef struct packed {
        logic  instr_valid;
        word_t pc;
        // faulting address, equals pc on a fetch fault
        word_t vaddr;
        logic  in_delay_slot;
        logic  eret;
        // fetch address error
        logic  exception_instr;
        // reserved instruction
        logic  exception_ri;
        // arithmetic overflow
        logic  exception_of;
        logic  exception_sys;
        logic  exception_bp;
        // data address error on load / store
        logic  exception_load;
        logic  exception_save;
    } exception_pipeline_t;

    // one ranked exception, handed to CP0 and to fetch
    typedef struct packed {
        logic      valid;
        exc_code_t code;
        word_t     pc;
        logic      in_delay_slot;
        word_t     badvaddr;
        // handler entry address
        word_t     location;
    } exception_t;

endpackage

`default_nettype wire

// ==== src.f ====
logic/mips_pkg.sv
logic/cp0_pkg.sv
logic/int_sync.sv
logic/exception.sv
logic/cp0_regs.sv
logic/exception_top.sv
testbench/exception_tb.sv

// ==== testbench/exception_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exception_tb
    import mips_pkg::*;
    import cp0_pkg::*;
();

    localparam int unsigned timeout_cycles = 3000;

    logic                clk;
    logic                rst_n;
    logic [n_hw_int-1:0] ext_int;
    exception_pipeline_t pipe;
    cp0_write_t          cp0_wr;
    cp0_reg_t            cp0_raddr;
    exception_t          exception;
    logic                exception_valid;
    word_t               pcexception;
    word_t               epc;
    word_t               cp0_rdata;

    // expected CP0 state
    logic        exp_exl;
    logic        exp_bd;
    word_t       exp_epc;
    word_t       exp_badvaddr;
    exc_code_t   exp_code;

    integer      seed;
    int unsigned cycle_count = 0;

    exception_top DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .ext_int         (ext_int),
        .pipe            (pipe),
        .cp0_wr          (cp0_wr),
        .cp0_raddr       (cp0_raddr),
        .exception       (exception),
        .exception_valid (exception_valid),
        .pcexception     (pcexception),
        .epc             (epc),
        .cp0_rdata       (cp0_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic expect_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // both the valid output and the record's valid bit
    task automatic compare_valid(input logic exp);
        expect_word("exception_valid", exception_valid, exp);
        expect_word("exception.valid", exception.valid, exp);
    endtask

    // flag order is {instr, ri, of, sys, bp, load, save}
    function automatic exception_pipeline_t make_pipe(input logic valid, input word_t pc,
            input word_t vaddr, input logic ds, input logic eret, input logic [6:0] flags);
        exception_pipeline_t p;
        p = '0;
        p.instr_valid = valid;
        p.pc = pc;
        p.vaddr = vaddr;
        p.in_delay_slot = ds;
        p.eret = eret;
        {p.exception_instr, p.exception_ri, p.exception_of, p.exception_sys,
         p.exception_bp, p.exception_load, p.exception_save} = flags;
        return p;
    endfunction

    // lowest rank first so the highest set flag overwrites the rest
    function automatic exc_code_t ranked_code(input logic [6:0] flags);
        logic [34:0] codes;
        exc_code_t   code;
        codes = {code_adel, code_ri, code_ov, code_sys, code_bp, code_adel, code_ades};
        code = code_int;
        for (int i = 0; i < 7; i++) begin
            if (flags[i]) begin
                code = exc_code_t'(codes[i*5 +: 5]);
            end
        end
        return code;
    endfunction

    function automatic void commit_model(input exc_code_t code, input word_t pc,
            input logic ds, input word_t vaddr);
        if (!exp_exl) begin
            exp_epc = ds ? pc - 32'd4 : pc;
            exp_bd = ds;
        end
        exp_code = code;
        exp_exl = 1'b1;
        if (code == code_adel || code == code_ades) begin
            exp_badvaddr = vaddr;
        end
    endfunction

    task automatic read_cp0(input cp0_reg_t addr, output word_t data);
        @(posedge clk);
        cp0_raddr <= addr;
        @(negedge clk);
        data = cp0_rdata;
    endtask

    // returns right after the edge that takes the write
    task automatic write_cp0(input cp0_reg_t addr, input word_t data);
        cp0_write_t w;
        w.valid = 1'b1;
        w.addr = addr;
        w.data = data;
        @(posedge clk);
        cp0_wr <= w;
        @(posedge clk);
        cp0_wr.valid <= 1'b0;
        if (addr == cp0_pkg::cp0_status) begin
            exp_exl = data[1];
        end
    endtask

    task automatic commit_exception(input word_t pc, input word_t vaddr, input logic ds,
            input logic eret, input logic [6:0] flags);
        @(posedge clk);
        pipe <= make_pipe(1'b1, pc, vaddr, ds, eret, flags);
        @(negedge clk);
        compare_valid(1'b1);
        expect_word("exception.code", exception.code, ranked_code(flags));
        commit_model(ranked_code(flags), pc, ds, vaddr);
        @(posedge clk);
        pipe <= '0;
        @(negedge clk);
        expect_word("epc", epc, exp_epc);
    endtask

    task automatic check_cp0_model();
        word_t       rd;
        cp0_cause_t  cause;
        cp0_status_t status;
        read_cp0(cp0_epc, rd);
        expect_word("EPC", rd, exp_epc);
        read_cp0(cp0_cause, rd);
        cause = rd;
        expect_word("Cause.BD", cause.BD, exp_bd);
        expect_word("Cause.ExcCode", cause.ExcCode, exp_code);
        read_cp0(cp0_badvaddr, rd);
        expect_word("BadVAddr", rd, exp_badvaddr);
        read_cp0(cp0_pkg::cp0_status, rd);
        status = rd;
        expect_word("Status.EXL", status.EXL, exp_exl);
    endtask

    // checks that hold on every cycle
    always @(negedge clk) begin
        expect_word("pcexception", pcexception, exc_entry);
        expect_word("exception.location", exception.location, exc_entry);
        if (!rst_n) begin
            compare_valid(1'b0);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
            stop_with_failure();
        end
    end

    initial begin
        exception_pipeline_t p;
        cp0_cause_t          cause;
        word_t               rd;
        logic [31:0]         r;
        logic [6:0]          flags;
        logic                found;
        int                  waited;
        seed = 32'h9a71_7e13;
        rst_n = 1'b0;
        // a faulting instruction during reset must stay masked
        pipe = make_pipe(1'b1, 32'h0040_0000, 32'h0040_0000, 1'b0, 1'b0, 7'b0100000);
        cp0_wr = '0;
        cp0_raddr = cp0_count;
        ext_int = '0;
        exp_exl = 1'b0;
        exp_bd = 1'b0;
        exp_epc = '0;
        exp_badvaddr = '0;
        exp_code = code_int;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        pipe <= '0;
        cp0_raddr <= cp0_cause;
        // timer latch sets one edge after reset and Cause is read before it
        @(negedge clk);
        expect_word("Cause", cp0_rdata, 32'h0);
        read_cp0(cp0_count, rd);
        expect_word("Count", rd, 32'h0);
        read_cp0(cp0_pkg::cp0_status, rd);
        expect_word("Status", rd, status_reset);
        read_cp0(cp0_epc, rd);
        expect_word("EPC", rd, 32'h0);

        // random priority with ERL keeping interrupts off
        for (int n = 0; n < 200; n++) begin
            r = $random(seed);
            flags = r[9:3] & r[16:10];
            p = make_pipe(r[1:0] != 2'b00, $random(seed), $random(seed), r[2], 1'b0, flags);
            @(posedge clk);
            pipe <= p;
            @(negedge clk);
            compare_valid(p.instr_valid && flags != 0);
            expect_word("exception.pc", exception.pc, p.pc);
            expect_word("exception.badvaddr", exception.badvaddr, p.vaddr);
            expect_word("exception.in_delay_slot", exception.in_delay_slot, p.in_delay_slot);
            if (p.instr_valid && flags != 0) begin
                expect_word("exception.code", exception.code, ranked_code(flags));
                commit_model(ranked_code(flags), p.pc, p.in_delay_slot, p.vaddr);
            end
        end
        @(posedge clk);
        pipe <= '0;
        check_cp0_model();

        // commit into CP0 and then a nested exception with EXL set
        write_cp0(cp0_pkg::cp0_status, 32'h0);
        commit_exception(32'h0040_0100, 32'h0040_0100, 1'b0, 1'b0, 7'b0001000);
        check_cp0_model();
        write_cp0(cp0_pkg::cp0_status, 32'h0);
        commit_exception(32'h0040_0208, 32'h1000_0003, 1'b1, 1'b0, 7'b0000010);
        check_cp0_model();
        commit_exception(32'h0040_0300, 32'h2000_0000, 1'b0, 1'b0, 7'b0100000);
        check_cp0_model();
        write_cp0(cp0_pkg::cp0_status, 32'h0);
        commit_exception(32'h0040_0404, 32'h3000_0002, 1'b1, 1'b0, 7'b0000001);
        check_cp0_model();

        // eret alone and then eret cancelled by a breakpoint
        @(posedge clk);
        pipe <= make_pipe(1'b1, 32'h0040_0500, 32'h0040_0500, 1'b0, 1'b1, 7'b0);
        @(negedge clk);
        compare_valid(1'b0);
        @(posedge clk);
        pipe <= '0;
        exp_exl = 1'b0;
        @(negedge clk);
        expect_word("epc", epc, exp_epc);
        check_cp0_model();
        commit_exception(32'h0040_0600, 32'h0040_0600, 1'b0, 1'b1, 7'b0000100);
        check_cp0_model();

        // external line 0 through the synchronizer with IE and IM[2] set
        write_cp0(cp0_pkg::cp0_status, 32'h0000_0401);
        @(posedge clk);
        ext_int <= 6'b000001;
        repeat (2) begin
            @(negedge clk);
            compare_valid(1'b0);
            @(posedge clk);
        end
        @(negedge clk);
        compare_valid(1'b1);
        expect_word("exception.code", exception.code, code_int);
        commit_model(code_int, 32'h0, 1'b0, 32'h0);
        @(posedge clk);
        @(negedge clk);
        compare_valid(1'b0);
        expect_word("epc", epc, exp_epc);
        write_cp0(cp0_pkg::cp0_status, 32'h0000_0001);
        repeat (3) begin
            @(negedge clk);
            compare_valid(1'b0);
        end
        write_cp0(cp0_pkg::cp0_status, 32'h0000_0401);
        pipe <= make_pipe(1'b1, 32'h0040_0700, 32'h0040_0700, 1'b1, 1'b0, 7'b0100000);
        @(negedge clk);
        compare_valid(1'b1);
        expect_word("exception.code", exception.code, code_int);
        commit_model(code_int, 32'h0040_0700, 1'b1, 32'h0040_0700);
        @(posedge clk);
        pipe <= '0;
        ext_int <= '0;
        check_cp0_model();

        // timer with Compare a few ticks ahead of Count
        read_cp0(cp0_count, rd);
        write_cp0(cp0_compare, rd + 32'd8);
        cp0_raddr <= cp0_cause;
        @(negedge clk);
        cause = cp0_rdata;
        expect_word("Cause.IP[7]", cause.IP[7], 1'b0);
        write_cp0(cp0_pkg::cp0_status, 32'h0000_8001);
        found = 1'b0;
        waited = 0;
        while (!found && waited < 40) begin
            @(negedge clk);
            cause = cp0_rdata;
            if (cause.IP[7]) begin
                found = 1'b1;
            end else begin
                waited++;
            end
        end
        assert (found) else begin
            $display("timer interrupt did not reach Cause.IP[7] within 40 cycles");
            stop_with_failure();
        end
        compare_valid(1'b1);
        expect_word("exception.code", exception.code, code_int);
        commit_model(code_int, 32'h0, 1'b0, 32'h0);
        write_cp0(cp0_compare, 32'hffff_0000);
        @(negedge clk);
        cause = cp0_rdata;
        expect_word("Cause.IP[7]", cause.IP[7], 1'b0);
        check_cp0_model();

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
